// File: src/dport_pkg.sv
package dport_pkg;

   // Bus geometry
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int SEL_W      = 4;                // One select per byte lane
   localparam int BYTE_W     = 8;

   // Address map
   localparam int ATOMIC_BIT = 31;               // Set = atomic alias of bus word
   localparam int WORD_LSB   = 2;                // Byte offset bits inside a word

   // Fields that travel with a strobe
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;                    // Write data
      logic [SEL_W-1:0]  sel;
      logic              we;
   } wb_req_t;

   // Slave response, one-cycle ack or err
   typedef struct packed {
      logic [DATA_W-1:0] dat;                    // Read data
      logic              ack;
      logic              err;
   } wb_rsp_t;

   // Decoded target of a core access
   typedef enum logic [1:0] {
      TGT_SCRATCH = 2'd0,
      TGT_BUS     = 2'd1,
      TGT_ATOMIC  = 2'd2
   } dport_tgt_e;

   // Bus master / compare-and-swap sequencer states
   typedef enum logic [2:0] {
      IDLE    = 3'd0,
      BUS_RD  = 3'd1,                            // Plain read on bus
      BUS_WR  = 3'd2,                            // Plain write on bus
      CAS_RD  = 3'd3,                            // Fetch old word
      CAS_CMP = 3'd4,                            // Old word vs expected
      CAS_WR  = 3'd5,                            // Store new word on match
      DONE    = 3'd6                             // Core response cycle
   } cas_state_e;

endpackage

// File: src/dport_addr_decode.sv
module dport_addr_decode #(
   parameter int SCRATCH_WORDS = 64              // Scratchpad depth in words
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  core_stb_i,     // Core strobe, already cyc-qualified
   input  dport_pkg::wb_req_t    core_req_i,
   output logic                  scr_stb_o,      // Strobe to scratchpad
   output logic                  bus_stb_o,      // Plain access to bus master
   output logic                  atm_stb_o,      // Atomic window access
   output dport_pkg::dport_tgt_e tgt_o           // Target of current address
);

   // Scratchpad boundary in bytes
   localparam int unsigned SCR_BYTES = SCRATCH_WORDS * dport_pkg::SEL_W;

   logic misaligned;                             // Low address bits nonzero
   logic in_scratch;
   logic ack_seen_q;                             // Scratchpad acked last cycle
   logic stb_ok;

   assign misaligned = |core_req_i.adr[dport_pkg::WORD_LSB-1:0];
   assign in_scratch = core_req_i.adr < SCR_BYTES;

   // Priority: misaligned, then atomic alias, then boundary
   always_comb begin
      if (misaligned) begin
         tgt_o = dport_pkg::TGT_BUS;             // Let the bus answer odd accesses
      end else if (core_req_i.adr[dport_pkg::ATOMIC_BIT]) begin
         tgt_o = dport_pkg::TGT_ATOMIC;
      end else if (in_scratch) begin
         tgt_o = dport_pkg::TGT_SCRATCH;
      end else begin
         tgt_o = dport_pkg::TGT_BUS;
      end
   end

   // Scratchpad acks in the strobe cycle, so its strobe is the ack
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_seen_q <= 1'b0;
      end else begin
         ack_seen_q <= scr_stb_o;
      end
   end

   // Held strobe right after an ack is not a new request
   assign stb_ok = core_stb_i && !ack_seen_q;

   // One-hot strobes, only while the core strobe is up
   assign scr_stb_o = stb_ok && (tgt_o == dport_pkg::TGT_SCRATCH);
   assign bus_stb_o = stb_ok && (tgt_o == dport_pkg::TGT_BUS);
   assign atm_stb_o = stb_ok && (tgt_o == dport_pkg::TGT_ATOMIC);

endmodule

// File: src/dport_scratch_mem.sv
module dport_scratch_mem #(
   parameter int SCRATCH_WORDS = 64              // Depth in words, power of two
) (
   input  logic               clk_i,
   input  logic               stb_i,             // Decoded scratchpad strobe
   input  dport_pkg::wb_req_t req_i,
   output dport_pkg::wb_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(SCRATCH_WORDS);

   logic [dport_pkg::DATA_W-1:0] mem_q [SCRATCH_WORDS];   // Word array
   logic [IDX_W-1:0]             idx;                     // Word index

   // Decoder guarantees the address is below the boundary
   assign idx = req_i.adr[dport_pkg::WORD_LSB +: IDX_W];

   // Byte-lane write at the edge closing the strobe cycle
   always_ff @(posedge clk_i) begin
      if (stb_i && req_i.we) begin
         for (int b = 0; b < dport_pkg::SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem_q[idx][b*dport_pkg::BYTE_W +: dport_pkg::BYTE_W] <=
                  req_i.dat[b*dport_pkg::BYTE_W +: dport_pkg::BYTE_W];
            end
         end
      end
   end

   // Same-cycle response, never errors
   always_comb begin
      rsp_o.dat = mem_q[idx];                    // Async read of addressed word
      rsp_o.ack = stb_i;
      rsp_o.err = 1'b0;
   end

endmodule

// File: src/dport_cas_unit.sv
module dport_cas_unit (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               bus_stb_i,         // Plain bus access
   input  logic               atm_stb_i,         // Atomic window access
   input  dport_pkg::wb_req_t req_i,             // Core request, held until response
   output dport_pkg::wb_rsp_t rsp_o,             // Response toward core
   output logic               bus_cyc_o,
   output logic               bus_stb_o,
   output dport_pkg::wb_req_t bus_req_o,
   input  dport_pkg::wb_rsp_t bus_rsp_i
);

   dport_pkg::cas_state_e        state_q;
   dport_pkg::cas_state_e        state_d;
   logic [dport_pkg::DATA_W-1:0] exp_q;          // Expected value, 1st atomic write
   logic [dport_pkg::DATA_W-1:0] new_q;          // Swap value, 2nd atomic write
   logic [dport_pkg::DATA_W-1:0] rd_q;           // Bus read data or old word
   logic [1:0]                   wr_cnt_q;       // Atomic writes so far
   logic                         err_q;          // Bus err seen in this access
   logic                         rel_q;          // Wait for strobe release
   logic                         bus_done;
   logic                         cmp_eq;
   logic                         rsp_fire;
   logic                         any_stb;
   logic                         accept;

   assign bus_done = bus_rsp_i.ack || bus_rsp_i.err;
   assign cmp_eq   = (rd_q == exp_q);            // Old word matches expected
   assign any_stb  = bus_stb_i || atm_stb_i;
   assign accept   = (state_q == dport_pkg::IDLE) && !rel_q;

   // Next state
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         dport_pkg::IDLE: begin
            if (!rel_q && bus_stb_i) begin
               state_d = req_i.we ? dport_pkg::BUS_WR : dport_pkg::BUS_RD;
            end else if (!rel_q && atm_stb_i) begin
               // Atomic writes only latch values, read starts the swap
               state_d = req_i.we ? dport_pkg::DONE : dport_pkg::CAS_RD;
            end
         end
         dport_pkg::BUS_RD, dport_pkg::BUS_WR, dport_pkg::CAS_WR: begin
            if (bus_done) begin
               state_d = dport_pkg::DONE;
            end
         end
         dport_pkg::CAS_RD: begin
            if (bus_rsp_i.err) begin
               state_d = dport_pkg::DONE;        // Abort sequence
            end else if (bus_rsp_i.ack) begin
               state_d = dport_pkg::CAS_CMP;
            end
         end
         dport_pkg::CAS_CMP: begin
            state_d = cmp_eq ? dport_pkg::CAS_WR : dport_pkg::IDLE;   // Mismatch acks here
         end
         dport_pkg::DONE: begin
            state_d = dport_pkg::IDLE;
         end
         default: begin
            state_d = dport_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= dport_pkg::IDLE;
         exp_q    <= '0;
         new_q    <= '0;
         rd_q     <= '0;
         wr_cnt_q <= '0;
         err_q    <= 1'b0;
         rel_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         // Expected value first, later writes replace the new value
         if (accept && atm_stb_i && req_i.we) begin
            if (wr_cnt_q == 2'd0) begin
               exp_q <= req_i.dat;
            end else begin
               new_q <= req_i.dat;
            end
            if (wr_cnt_q != 2'd2) begin
               wr_cnt_q <= wr_cnt_q + 2'd1;
            end
         end
         if ((state_q == dport_pkg::BUS_RD || state_q == dport_pkg::CAS_RD) &&
             bus_rsp_i.ack) begin
            rd_q <= bus_rsp_i.dat;
         end
         if (state_q == dport_pkg::CAS_RD && bus_done) begin
            wr_cnt_q <= '0;                      // Read closes the sequence
         end
         if (state_q == dport_pkg::IDLE) begin
            err_q <= 1'b0;
         end else if (bus_stb_o && bus_rsp_i.err) begin
            err_q <= 1'b1;
         end
         // Held while the core keeps strobing after its response
         rel_q <= (rsp_fire || rel_q) && any_stb;
      end
   end

   // Bus side, single transfers so cyc follows stb
   assign bus_stb_o = (state_q == dport_pkg::BUS_RD) || (state_q == dport_pkg::BUS_WR) ||
                      (state_q == dport_pkg::CAS_RD) || (state_q == dport_pkg::CAS_WR);
   assign bus_cyc_o = bus_stb_o;

   always_comb begin
      bus_req_o                         = req_i;   // Stable while core holds request
      bus_req_o.adr[dport_pkg::ATOMIC_BIT] = 1'b0; // Strip atomic alias
      bus_req_o.we = (state_q == dport_pkg::BUS_WR) || (state_q == dport_pkg::CAS_WR);
      if (state_q == dport_pkg::CAS_WR) begin
         bus_req_o.dat = new_q;
      end
   end

   // Core response, old word returned on both CAS outcomes
   always_comb begin
      rsp_o.dat = rd_q;
      rsp_o.ack = ((state_q == dport_pkg::DONE) && !err_q) ||
                  ((state_q == dport_pkg::CAS_CMP) && !cmp_eq);
      rsp_o.err = (state_q == dport_pkg::DONE) && err_q;
   end

   assign rsp_fire = rsp_o.ack || rsp_o.err;

endmodule

// File: src/dport_resp_mux.sv
module dport_resp_mux (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  core_stb_i,     // Core strobe, cyc-qualified
   input  dport_pkg::dport_tgt_e tgt_i,          // Live decode of core address
   input  dport_pkg::wb_rsp_t    scr_rsp_i,
   input  dport_pkg::wb_rsp_t    cas_rsp_i,
   output dport_pkg::wb_rsp_t    core_rsp_o
);

   logic                  active_q;              // Request in flight past 1st cycle
   dport_pkg::dport_tgt_e tgt_q;                 // Target latched at request start
   dport_pkg::dport_tgt_e tgt_sel;

   // First cycle uses live decode, scratchpad answers there
   assign tgt_sel = active_q ? tgt_q : tgt_i;

   always_comb begin
      unique case (tgt_sel)
         dport_pkg::TGT_SCRATCH: core_rsp_o = scr_rsp_i;
         dport_pkg::TGT_BUS, dport_pkg::TGT_ATOMIC: core_rsp_o = cas_rsp_i;
         default: core_rsp_o = '0;
      endcase
      if (!core_stb_i) begin
         core_rsp_o.ack = 1'b0;                  // No handshake outside a request
         core_rsp_o.err = 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         active_q <= 1'b0;
         tgt_q    <= dport_pkg::TGT_SCRATCH;
      end else begin
         active_q <= core_stb_i && !(core_rsp_o.ack || core_rsp_o.err);
         if (!active_q) begin
            tgt_q <= tgt_i;                      // Hold until response
         end
      end
   end

endmodule

// File: src/dport_top.sv
module dport_top #(
   parameter int SCRATCH_WORDS = 64              // Scratchpad depth in words
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   // Core data port
   input  logic               core_cyc_i,
   input  logic               core_stb_i,
   input  dport_pkg::wb_req_t core_req_i,
   output dport_pkg::wb_rsp_t core_rsp_o,
   // External bus
   output logic               bus_cyc_o,
   output logic               bus_stb_o,
   output dport_pkg::wb_req_t bus_req_o,
   input  dport_pkg::wb_rsp_t bus_rsp_i
);

   logic                  core_act;              // Strobe inside a cycle
   logic                  scr_stb;
   logic                  bus_stb;
   logic                  atm_stb;
   dport_pkg::dport_tgt_e tgt;
   dport_pkg::wb_rsp_t    scr_rsp;
   dport_pkg::wb_rsp_t    cas_rsp;

   assign core_act = core_cyc_i && core_stb_i;

   dport_addr_decode #(
      .SCRATCH_WORDS (SCRATCH_WORDS)
   ) u_decode (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_stb_i (core_act),
      .core_req_i (core_req_i),
      .scr_stb_o  (scr_stb),
      .bus_stb_o  (bus_stb),
      .atm_stb_o  (atm_stb),
      .tgt_o      (tgt)
   );

   dport_scratch_mem #(
      .SCRATCH_WORDS (SCRATCH_WORDS)
   ) u_scratch (
      .clk_i (clk_i),
      .stb_i (scr_stb),
      .req_i (core_req_i),
      .rsp_o (scr_rsp)
   );

   dport_cas_unit u_cas (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .bus_stb_i (bus_stb),
      .atm_stb_i (atm_stb),
      .req_i     (core_req_i),
      .rsp_o     (cas_rsp),
      .bus_cyc_o (bus_cyc_o),
      .bus_stb_o (bus_stb_o),
      .bus_req_o (bus_req_o),
      .bus_rsp_i (bus_rsp_i)
   );

   dport_resp_mux u_resp (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_stb_i (core_act),
      .tgt_i      (tgt),
      .scr_rsp_i  (scr_rsp),
      .cas_rsp_i  (cas_rsp),
      .core_rsp_o (core_rsp_o)
   );

endmodule

// File: tests/dport_props.sv
module dport_props (
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               core_cyc_i,
   input logic               core_stb_i,
   input dport_pkg::wb_rsp_t core_rsp_i,
   input logic               bus_cyc_i,
   input logic               bus_stb_i,
   input dport_pkg::wb_req_t bus_req_i,
   input dport_pkg::wb_rsp_t bus_rsp_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;                             // Read by the testbench at the end

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      core_stb_i |-> core_cyc_i)
      else begin
         $error("Core strobe outside a bus cycle");
         fail_cnt++;
      end

   // Both handshakes, core and bus
   a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(core_rsp_i.ack && core_rsp_i.err) && !(bus_rsp_i.ack && bus_rsp_i.err))
      else begin
         $error("Ack and err high together");
         fail_cnt++;
      end

   // Unanswered bus request holds until ack or err
   a_bus_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bus_stb_i && !bus_rsp_i.ack && !bus_rsp_i.err |=> bus_stb_i && $stable(bus_req_i))
      else begin
         $error("Bus request changed while waiting for a response");
         fail_cnt++;
      end

   a_idle_after_reset: assert property (@(posedge clk_i)
      !rst_n_i |=> !bus_stb_i && !bus_cyc_i)
      else begin
         $error("Bus strobe high in the cycle after reset");
         fail_cnt++;
      end

endmodule

bind dport_top dport_props u_props (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .core_cyc_i (core_cyc_i),
   .core_stb_i (core_stb_i),
   .core_rsp_i (core_rsp_o),
   .bus_cyc_i  (bus_cyc_o),
   .bus_stb_i  (bus_stb_o),
   .bus_req_i  (bus_req_o),
   .bus_rsp_i  (bus_rsp_i)
);

// File: tests/tb_dport.sv
module tb_dport;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          SCRATCH_WORDS = 64;
   localparam int          HALF_PERIOD   = 10;             // 20 ns clock
   localparam int          TIMEOUT       = 50;             // Cycles per response wait
   localparam logic [31:0] BUS_LIMIT     = 32'h0010_0000;  // Bus model errs from here up

   logic               clk;
   logic               rst_n;
   logic               core_cyc;
   logic               core_stb;
   dport_pkg::wb_req_t core_req;
   dport_pkg::wb_rsp_t core_rsp;
   logic               bus_cyc;
   logic               bus_stb;
   dport_pkg::wb_req_t bus_req;
   dport_pkg::wb_rsp_t bus_rsp;

   logic [31:0] bus_mem [logic [31:0]];          // Sparse bus memory keyed by word address
   string       cur_name = "reset";
   int          checks;
   int          errors;
   int          timeouts;
   int          bus_strobes;                     // Bus requests seen by the model
   int          bus_writes;

   dport_top #(
      .SCRATCH_WORDS (SCRATCH_WORDS)
   ) dut (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .core_cyc_i (core_cyc),
      .core_stb_i (core_stb),
      .core_req_i (core_req),
      .core_rsp_o (core_rsp),
      .bus_cyc_o  (bus_cyc),
      .bus_stb_o  (bus_stb),
      .bus_req_o  (bus_req),
      .bus_rsp_i  (bus_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Unwritten bus words read back a pattern of their address
   function automatic logic [31:0] fill_word(input logic [31:0] adr);
      return adr ^ 32'hc3c3_0000;
   endfunction

   // Odd offsets go to the bus ahead of atomic alias and scratchpad boundary
   function automatic dport_pkg::dport_tgt_e target_of(input logic [31:0] adr);
      if (adr[1:0] != 2'b00) return dport_pkg::TGT_BUS;
      if (adr[31]) return dport_pkg::TGT_ATOMIC;
      if (adr < 32'(SCRATCH_WORDS * 4)) return dport_pkg::TGT_SCRATCH;
      return dport_pkg::TGT_BUS;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         $display("ERR %s %s expected %h actual %h", cur_name, what, exp, act);
         errors++;
      end
   endtask

   // One core access held until ack or err and then released for a cycle
   task automatic run_access(input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, input logic we, output logic ack,
                             output logic err, output logic [31:0] rdat, output int lat);
      logic done;
      done = 1'b0;
      lat  = 0;
      @(negedge clk);
      core_req.adr = adr;
      core_req.dat = wdat;
      core_req.sel = sel;
      core_req.we  = we;
      core_cyc     = 1'b1;
      core_stb     = 1'b1;
      while (!done && lat <= TIMEOUT) begin
         #(HALF_PERIOD / 2);                     // Midway through low phase
         ack  = core_rsp.ack;
         err  = core_rsp.err;
         rdat = core_rsp.dat;
         done = ack || err;
         if (!done) begin
            @(negedge clk);
            lat++;
         end
      end
      if (!done) begin
         $display("Timeout: no core ack or err within %0d cycles in test %s", TIMEOUT, cur_name);
         timeouts++;
      end
      @(negedge clk);
      core_cyc = 1'b0;
      core_stb = 1'b0;
   endtask

   // Bus slave model with random 0..3 cycle ack delay
   initial begin : bus_model
      logic [31:0] wadr;
      logic [31:0] word;
      int unsigned delay;
      void'($urandom(32'h9ccb_6bba));
      bus_rsp = '0;
      forever begin
         @(negedge clk);
         bus_rsp.ack = 1'b0;                     // One-cycle response pulse
         bus_rsp.err = 1'b0;
         if (bus_cyc && bus_stb) begin
            bus_strobes++;
            if (bus_req.we) bus_writes++;
            check_value("bus address", {1'b0, core_req.adr[30:0]}, bus_req.adr);
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            wadr = {bus_req.adr[31:2], 2'b00};
            if (wadr >= BUS_LIMIT) begin
               bus_rsp.err = 1'b1;               // Outside modelled range
            end else begin
               word = bus_mem.exists(wadr) ? bus_mem[wadr] : fill_word(wadr);
               if (bus_req.we) begin
                  for (int b = 0; b < 4; b++) begin
                     if (bus_req.sel[b]) word[b*8 +: 8] = bus_req.dat[b*8 +: 8];
                  end
                  bus_mem[wadr] = word;
               end
               bus_rsp.dat = word;
               bus_rsp.ack = 1'b1;
            end
         end
      end
   end

   initial begin : main
      int                    fd;
      int                    n;
      string                 line;
      logic [8*16-1:0]       name_v;
      logic [7:0]            rw;
      logic [31:0]           adr;
      logic [31:0]           wdat;
      logic [3:0]            sel;
      logic [31:0]           exp_rd;
      logic [31:0]           cas_exp;            // Expected value of open CAS sequence
      int                    cas_cnt;
      logic                  we;
      logic                  exp_err;
      int                    exp_stb;
      int                    exp_wr;
      int                    stb0;
      int                    wr0;
      logic                  ack;
      logic                  err;
      logic [31:0]           rdat;
      int                    lat;
      dport_pkg::dport_tgt_e tgt;
      rst_n    = 1'b0;
      core_cyc = 1'b0;
      core_stb = 1'b0;
      core_req = '0;
      cas_exp  = '0;
      cas_cnt  = 0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      fd = $fopen("tests/dport_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open stimulus file tests/dport_input.txt");
         errors++;
      end
      while (fd != 0 && !$feof(fd) && timeouts == 0) begin
         n = $fgets(line, fd);
         if (n > 1 && line[0] != "#") begin
            n = $sscanf(line, "%s %s %h %h %h %h", name_v, rw, adr, wdat, sel, exp_rd);
            if (n != 6) begin
               $display("Malformed stimulus line: %s", line);
               errors++;
            end else begin
               cur_name = $sformatf("%0s", name_v);
               we       = (rw == "W");
               tgt      = target_of(adr);
               // Bus is reached by plain bus accesses and atomic reads only
               exp_err  = tgt != dport_pkg::TGT_SCRATCH &&
                          !(tgt == dport_pkg::TGT_ATOMIC && we) &&
                          {1'b0, adr[30:0]} >= BUS_LIMIT;
               exp_stb  = (tgt == dport_pkg::TGT_BUS) ? 1 : 0;
               exp_wr   = (tgt == dport_pkg::TGT_BUS && we) ? 1 : 0;
               if (tgt == dport_pkg::TGT_ATOMIC && we) begin
                  if (cas_cnt == 0) cas_exp = wdat;   // First write is expected value
                  cas_cnt++;
               end else if (tgt == dport_pkg::TGT_ATOMIC) begin
                  exp_stb = (!exp_err && exp_rd == cas_exp) ? 2 : 1;   // Write back on match
                  exp_wr  = exp_stb - 1;
                  cas_cnt = 0;
               end
               stb0 = bus_strobes;
               wr0  = bus_writes;
               run_access(adr, wdat, sel, we, ack, err, rdat, lat);
               if (lat <= TIMEOUT) begin
                  check_value("err flag", 32'(exp_err), 32'(err));
                  check_value("ack flag", 32'(!exp_err), 32'(ack));
                  if (!we && !exp_err) check_value("read data", exp_rd, rdat);
                  if (tgt == dport_pkg::TGT_SCRATCH) check_value("latency", 0, 32'(lat));
                  check_value("bus strobes", 32'(exp_stb), 32'(bus_strobes - stb0));
                  check_value("bus writes", 32'(exp_wr), 32'(bus_writes - wr0));
               end
            end
         end
      end
      if (fd != 0) $fclose(fd);
      $display("Checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
               checks, errors, timeouts, dut.u_props.fail_cnt);
      if (errors == 0 && timeouts == 0 && dut.u_props.fail_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: tests/dport_input.txt
# name  rw(R/W)  address  write_data  sel  expected_read_data   (all hex)
# bit 31 of the address selects the atomic alias; bus model errs at 00100000 and up
scr_full   W 00000010 11223344 f 00000000
scr_b0     W 00000010 000000aa 1 00000000
scr_b3     W 00000010 bb000000 8 00000000
scr_merge  R 00000010 00000000 f bb2233aa
bus_wr     W 00000100 deadbeef f 00000000
bus_half   W 00000100 00001234 3 00000000
bus_rd     R 00000100 00000000 f dead1234
bus_fill   R 00002000 00000000 f c3c32000
cas_init   W 00000400 00000005 f 00000000
cas_exp    W 80000400 00000005 f 00000000
cas_new    W 80000400 00000009 f 00000000
cas_swap   R 80000400 00000000 f 00000005
cas_chk    R 00000400 00000000 f 00000009
bad_exp    W 80000400 00000007 f 00000000
bad_new    W 80000400 00000011 f 00000000
bad_swap   R 80000400 00000000 f 00000009
bad_chk    R 00000400 00000000 f 00000009
err_rd     R 00100000 00000000 f 00000000
err_wr     W 00100004 12345678 f 00000000
err_swap   R 80100000 00000000 f 00000000
scr_keep   R 00000010 00000000 f bb2233aa

// File: compile.f
src/dport_pkg.sv
src/dport_addr_decode.sv
src/dport_scratch_mem.sv
src/dport_cas_unit.sv
src/dport_resp_mux.sv
src/dport_top.sv
tests/dport_props.sv
tests/tb_dport.sv

// File: Makefile
TOP := tb_dport

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "Test failed, see sim.log"; exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "Run ended early, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
